//--- common/biu_types_pkg.sv
/*
 * Vector types shared across the bus interface unit.
 * Segments, offsets, physical word addresses and bus data all
 * travel under these names so that widths stay consistent.
 * Import where the types are needed inside a module body.
 */

`default_nettype none

package biu_types_pkg;

    // segment register value
    typedef logic [15:0] seg_t;

    // offset within a segment, IP or data offset
    typedef logic [15:0] offset_t;

    // physical word address, byte bit 0 is implied by the lanes
    typedef logic [19:1] phys_waddr_t;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;

    // bit 0 low byte, bit 1 high byte
    typedef logic [1:0]  bytesel_t;

endpackage

`default_nettype wire

//--- common/biu_bus_pkg.sv
/*
 * Bus-level definitions: state encodings for the arbiter and the
 * data access sequencer, plus default configuration values.
 */

`default_nettype none

package biu_bus_pkg;

    typedef enum logic [1:0] {
        arb_idle,
        arb_data_owned,
        arb_fetch_owned
    } arb_state_t;

    typedef enum logic [1:0] {
        acc_idle,
        acc_first,
        acc_second,
        acc_finish
    } acc_state_t;

    // instruction byte FIFO depth
    parameter int default_fifo_depth = 6;

endpackage

`default_nettype wire

//--- common/mem_req_if.sv
/*
 * One memory requester's connection to the bus arbiter.
 * The requester holds access, address and write data stable until
 * it sees ack for one cycle, then drops access or presents a new
 * request. Read data is only meaningful in the ack cycle.
 */

`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;
    import biu_types_pkg::*;

    logic        access;
    logic        write;
    phys_waddr_t address;
    bytesel_t    bytesel;
    word_t       wr_data;
    word_t       rd_data;
    logic        ack;

    modport requester (
        output access,
        output write,
        output address,
        output bytesel,
        output wr_data,
        input  rd_data,
        input  ack
    );

    modport arbiter (
        input  access,
        input  write,
        input  address,
        input  bytesel,
        input  wr_data,
        output rd_data,
        output ack
    );

endinterface

`default_nettype wire

//--- prefetch/prefetch.sv
/*
 * Instruction prefetcher. Fetches 16-bit words at CS:IP and pushes
 * them into the instruction FIFO one byte at a time. Loading a new
 * CS:IP flushes the FIFO in the same cycle; a fetch already on the
 * bus completes with its address unchanged and its data discarded.
 * The first byte of a word lands in the ack cycle, the high byte of
 * an even-addressed word one cycle later.
 */

`timescale 1ns/1ps
`default_nettype none

module prefetch (
    input  logic                   clk,
    input  logic                   reset,
    input  biu_types_pkg::seg_t    new_cs,
    input  biu_types_pkg::offset_t new_ip,
    input  logic                   load_new_ip,
    output logic                   fifo_wr_en,
    output biu_types_pkg::byte_t   fifo_wr_data,
    output logic                   fifo_reset,
    input  logic                   fifo_full,
    mem_req_if.requester           mem
);
    import biu_types_pkg::*;

    seg_t        cs;
    offset_t     fetch_ip;
    phys_waddr_t cur_waddr;
    phys_waddr_t held_waddr;
    byte_t       high_byte;
    logic        active;
    logic        abort_cur;
    logic        write_second;
    logic        ack_taken;

    // ack belonging to a fetch that is still wanted
    assign ack_taken = mem.ack && !abort_cur;

    // segment << 4 plus offset, expressed in words
    assign cur_waddr = {cs, 3'b000} + {4'b0000, fetch_ip[15:1]};

    assign mem.access  = active && !fifo_full && !mem.ack && !write_second;
    assign mem.write   = 1'b0;
    assign mem.address = abort_cur ? held_waddr : cur_waddr;
    assign mem.bytesel = 2'b11;
    assign mem.wr_data = '0;

    assign fifo_reset   = load_new_ip;
    assign fifo_wr_en   = !load_new_ip && (ack_taken || write_second);
    assign fifo_wr_data = mem.ack ? (fetch_ip[0] ? mem.rd_data[15:8] : mem.rd_data[7:0])
                                  : high_byte;

    // first clock edge after reset enables fetching
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active <= 1'b0;
        end else begin
            active <= 1'b1;
        end
    end

    // swallow the ack of a fetch overtaken by an IP load
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            abort_cur <= 1'b0;
        end else if (abort_cur && mem.ack) begin
            abort_cur <= 1'b0;
        end else if (mem.access && load_new_ip) begin
            abort_cur <= 1'b1;
        end
    end

    // keep the aborted request's address on the bus until its ack
    always_ff @(posedge clk) begin
        if (mem.access && load_new_ip && !abort_cur) begin
            held_waddr <= cur_waddr;
        end
    end

    // a reload in the ack cycle cancels the pending high byte too
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            write_second <= 1'b0;
        end else begin
            write_second <= ack_taken && !load_new_ip && !fetch_ip[0];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cs       <= '0;
            fetch_ip <= '0;
        end else if (load_new_ip) begin
            cs       <= new_cs;
            fetch_ip <= new_ip;
        end else if (ack_taken || write_second) begin
            fetch_ip <= fetch_ip + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem.ack) begin
            high_byte <= mem.rd_data[15:8];
        end
    end

endmodule

`default_nettype wire

//--- prefetch/insn_fifo.sv
/*
 * Instruction byte FIFO between the prefetcher and the decoder.
 * Circular buffer with an occupancy count. full is raised early,
 * while fewer than two slots are free, so a word fetch started
 * below that level always has room for both bytes. flush empties
 * the buffer on the next clock edge.
 */

`timescale 1ns/1ps
`default_nettype none

module insn_fifo #(
    parameter int DEPTH = biu_bus_pkg::default_fifo_depth
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 wr_en,
    input  biu_types_pkg::byte_t wr_data,
    input  logic                 rd_en,
    output biu_types_pkg::byte_t rd_data,
    output logic                 valid,
    output logic                 full
);
    import biu_types_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    byte_t            store [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (int'(ptr) == DEPTH - 1) ? '0 : ptr + 1'b1;
    endfunction

    assign valid   = (count != '0);
    assign full    = (int'(count) > DEPTH - 2);
    assign rd_data = store[rd_ptr];

    // reads of an empty buffer are ignored
    assign do_rd = rd_en && valid;
    assign do_wr = wr_en && (int'(count) < DEPTH);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr && !flush) begin
            store[wr_ptr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/data_access.sv
/*
 * Load/store sequencer for the execution unit's data accesses.
 * A start pulse in idle latches the request. Byte and even-addressed
 * word accesses take one bus cycle; a word at an odd address becomes
 * two byte cycles, odd byte first, then the low byte of the next
 * word. done pulses one cycle after the last ack with rd_data valid.
 */

`timescale 1ns/1ps
`default_nettype none

module data_access (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   write,
    input  logic                   word,
    input  biu_types_pkg::seg_t    seg,
    input  biu_types_pkg::offset_t offset,
    input  biu_types_pkg::word_t   wr_data,
    output biu_types_pkg::word_t   rd_data,
    output logic                   done,
    mem_req_if.requester           mem
);
    import biu_types_pkg::*;
    import biu_bus_pkg::*;

    acc_state_t  state;
    logic        op_write;
    logic        op_word;
    logic [19:0] byte_addr;
    word_t       op_data;
    word_t       result;
    phys_waddr_t first_waddr;
    logic        odd;
    logic        split;

    assign odd         = byte_addr[0];
    assign split       = op_word && odd;
    assign first_waddr = byte_addr[19:1];

    assign mem.access  = ((state == acc_first) || (state == acc_second)) && !mem.ack;
    assign mem.write   = op_write;
    assign mem.address = (state == acc_second) ? first_waddr + 1'b1 : first_waddr;

    // write bytes are copied to both lanes, bytesel picks the live one
    always_comb begin
        if (state == acc_second) begin
            mem.bytesel = 2'b01;
            mem.wr_data = {op_data[15:8], op_data[15:8]};
        end else if (op_word && !odd) begin
            mem.bytesel = 2'b11;
            mem.wr_data = op_data;
        end else begin
            mem.bytesel = odd ? 2'b10 : 2'b01;
            mem.wr_data = {op_data[7:0], op_data[7:0]};
        end
    end

    assign rd_data = result;
    assign done    = (state == acc_finish);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= acc_idle;
        end else begin
            case (state)
                acc_idle:   if (start) state <= acc_first;
                acc_first:  if (mem.ack) state <= split ? acc_second : acc_finish;
                acc_second: if (mem.ack) state <= acc_finish;
                acc_finish: state <= acc_idle;
                default:    state <= acc_idle;
            endcase
        end
    end

    // request latch and read assembly
    always_ff @(posedge clk) begin
        if (state == acc_idle && start) begin
            op_write  <= write;
            op_word   <= word;
            byte_addr <= {seg, 4'h0} + {4'h0, offset};
            op_data   <= wr_data;
        end
        if (state == acc_first && mem.ack) begin
            if (split) begin
                result[7:0] <= mem.rd_data[15:8];
            end else if (op_word) begin
                result <= mem.rd_data;
            end else begin
                result <= {8'h00, odd ? mem.rd_data[15:8] : mem.rd_data[7:0]};
            end
        end
        if (state == acc_second && mem.ack) begin
            result[15:8] <= mem.rd_data[7:0];
        end
    end

endmodule

`default_nettype wire

//--- rtl/bus_arbiter.sv
/*
 * Fixed-priority arbiter for the single external memory port.
 * From idle a request is granted in the same cycle, data before
 * fetch, and ownership is held until the memory acks. Ack and read
 * data go back to the owner only. The memory acks no earlier than
 * the cycle after an access starts.
 */

`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  logic                       clk,
    input  logic                       reset,
    mem_req_if.arbiter                 data_req,
    mem_req_if.arbiter                 fetch_req,
    output logic                       mem_access,
    output logic                       mem_write,
    output biu_types_pkg::phys_waddr_t mem_address,
    output biu_types_pkg::bytesel_t    mem_bytesel,
    output biu_types_pkg::word_t       mem_wr_data,
    input  biu_types_pkg::word_t       mem_data,
    input  logic                       mem_ack
);
    import biu_bus_pkg::*;

    arb_state_t state;
    logic       grant_data;
    logic       grant_fetch;

    assign grant_data  = (state == arb_data_owned) ||
                         (state == arb_idle && data_req.access);
    assign grant_fetch = (state == arb_fetch_owned) ||
                         (state == arb_idle && !data_req.access && fetch_req.access);

    // owner's request onto the external bus
    always_comb begin
        if (grant_data) begin
            mem_access  = data_req.access;
            mem_write   = data_req.write;
            mem_address = data_req.address;
            mem_bytesel = data_req.bytesel;
            mem_wr_data = data_req.wr_data;
        end else begin
            mem_access  = grant_fetch && fetch_req.access;
            mem_write   = fetch_req.write;
            mem_address = fetch_req.address;
            mem_bytesel = fetch_req.bytesel;
            mem_wr_data = fetch_req.wr_data;
        end
    end

    assign data_req.ack      = mem_ack && (state == arb_data_owned);
    assign data_req.rd_data  = (state == arb_data_owned) ? mem_data : '0;
    assign fetch_req.ack     = mem_ack && (state == arb_fetch_owned);
    assign fetch_req.rd_data = (state == arb_fetch_owned) ? mem_data : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= arb_idle;
        end else begin
            case (state)
                arb_idle: begin
                    if (data_req.access) begin
                        state <= arb_data_owned;
                    end else if (fetch_req.access) begin
                        state <= arb_fetch_owned;
                    end
                end
                arb_data_owned:  if (mem_ack) state <= arb_idle;
                arb_fetch_owned: if (mem_ack) state <= arb_idle;
                default:         state <= arb_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/biu_top.sv
/*
 * Bus interface unit top level. Connects the instruction prefetcher
 * and its byte FIFO, the data access sequencer and the bus arbiter,
 * and exposes the code, instruction, data and memory sides as plain
 * ports. FIFO_DEPTH sets the instruction FIFO size.
 */

`timescale 1ns/1ps
`default_nettype none

module biu_top #(
    parameter int FIFO_DEPTH = biu_bus_pkg::default_fifo_depth
) (
    input  logic                       clk,
    input  logic                       reset,
    // code side
    input  biu_types_pkg::seg_t        new_cs,
    input  biu_types_pkg::offset_t     new_ip,
    input  logic                       load_new_ip,
    // instruction stream
    input  logic                       insn_rd_en,
    output biu_types_pkg::byte_t       insn_data,
    output logic                       insn_valid,
    // data side
    input  logic                       data_start,
    input  logic                       data_write,
    input  logic                       data_word,
    input  biu_types_pkg::seg_t        data_seg,
    input  biu_types_pkg::offset_t     data_offset,
    input  biu_types_pkg::word_t       data_wr_data,
    output biu_types_pkg::word_t       data_rd_data,
    output logic                       data_done,
    // external memory
    output logic                       mem_access,
    output logic                       mem_write,
    output biu_types_pkg::phys_waddr_t mem_address,
    output biu_types_pkg::bytesel_t    mem_bytesel,
    output biu_types_pkg::word_t       mem_wr_data,
    input  biu_types_pkg::word_t       mem_data,
    input  logic                       mem_ack
);
    import biu_types_pkg::*;

    logic  fifo_wr_en;
    byte_t fifo_wr_data;
    logic  fifo_reset;
    logic  fifo_full;

    mem_req_if data_bus ();
    mem_req_if fetch_bus ();

    prefetch u_prefetch (
        .clk          (clk),
        .reset        (reset),
        .new_cs       (new_cs),
        .new_ip       (new_ip),
        .load_new_ip  (load_new_ip),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_wr_data (fifo_wr_data),
        .fifo_reset   (fifo_reset),
        .fifo_full    (fifo_full),
        .mem          (fetch_bus)
    );

    insn_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_insn_fifo (
        .clk     (clk),
        .reset   (reset),
        .flush   (fifo_reset),
        .wr_en   (fifo_wr_en),
        .wr_data (fifo_wr_data),
        .rd_en   (insn_rd_en),
        .rd_data (insn_data),
        .valid   (insn_valid),
        .full    (fifo_full)
    );

    data_access u_data_access (
        .clk     (clk),
        .reset   (reset),
        .start   (data_start),
        .write   (data_write),
        .word    (data_word),
        .seg     (data_seg),
        .offset  (data_offset),
        .wr_data (data_wr_data),
        .rd_data (data_rd_data),
        .done    (data_done),
        .mem     (data_bus)
    );

    bus_arbiter u_bus_arbiter (
        .clk         (clk),
        .reset       (reset),
        .data_req    (data_bus),
        .fetch_req   (fetch_bus),
        .mem_access  (mem_access),
        .mem_write   (mem_write),
        .mem_address (mem_address),
        .mem_bytesel (mem_bytesel),
        .mem_wr_data (mem_wr_data),
        .mem_data    (mem_data),
        .mem_ack     (mem_ack)
    );

endmodule

`default_nettype wire

//--- testbench/biu_mem_model.sv
/*
 * Behavioural word memory for the bus interface unit testbench.
 * Each access is answered with a one-cycle ack after 1 to 4 cycles.
 * Unwritten words read back a pattern built from the word address.
 * Writes honour the byte lanes.
 */

`timescale 1ns/1ps
`default_nettype none

module biu_mem_model #(
    parameter logic [31:0] SEED = 32'h1
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        access,
    input  logic        write,
    input  logic [19:1] address,
    input  logic [1:0]  bytesel,
    input  logic [15:0] wr_data,
    output logic [15:0] rd_data,
    output logic        ack
);
    logic [15:0] words [logic [18:0]];
    logic [31:0] rng = SEED;
    logic        busy = 1'b0;
    int          wait_left = 0;
    logic [15:0] cur;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // upper address bits are folded in so the whole address counts
    function automatic logic [15:0] fill_word(input logic [18:0] wa);
        return wa[15:0] ^ {13'b0, wa[18:16]} ^ 16'h5a3c;
    endfunction

    function automatic logic [15:0] read_word(input logic [18:0] wa);
        return words.exists(wa) ? words[wa] : fill_word(wa);
    endfunction

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            ack       <= 1'b0;
            rd_data   <= '0;
            busy      = 1'b0;
            wait_left = 0;
        end else begin
            ack <= 1'b0;
            // new request, pick its delay
            if (!busy && !ack && access) begin
                rng       = xorshift(rng);
                wait_left = int'(rng % 4);
                busy      = 1'b1;
            end
            if (busy) begin
                if (wait_left == 0) begin
                    cur = read_word(address);
                    if (write) begin
                        if (bytesel[0]) cur[7:0] = wr_data[7:0];
                        if (bytesel[1]) cur[15:8] = wr_data[15:8];
                        words[address] = cur;
                    end
                    rd_data <= cur;
                    ack     <= 1'b1;
                    busy    = 1'b0;
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/biu_tb.sv
/*
 * Testbench for the bus interface unit. Random instruction fetch
 * phases with IP reloads and reader stalls run alongside random
 * data loads and stores; every consumed byte and every read result
 * is compared with a byte-level memory model kept here.
 */

`timescale 1ns/1ps
`default_nettype none

module biu_tb;
    import biu_types_pkg::*;

    localparam logic [31:0] seed = 32'hb729_12dc;
    localparam int timeout_cycles = 200;
    localparam int num_phases = 40;

    logic        clk = 1'b0;
    logic        reset;
    seg_t        new_cs;
    offset_t     new_ip;
    logic        load_new_ip;
    logic        insn_rd_en;
    byte_t       insn_data;
    logic        insn_valid;
    logic        data_start;
    logic        data_write;
    logic        data_word;
    seg_t        data_seg;
    offset_t     data_offset;
    word_t       data_wr_data;
    word_t       data_rd_data;
    logic        data_done;
    logic        mem_access;
    logic        mem_write;
    phys_waddr_t mem_address;
    bytesel_t    mem_bytesel;
    word_t       mem_wr_data;
    word_t       mem_data;
    logic        mem_ack;

    // bytes stored by data writes, keyed by physical byte address
    byte_t written [logic [19:0]];
    int    error_count = 0;

    always #4 clk = ~clk;

    biu_top u_biu_top (
        .clk          (clk),
        .reset        (reset),
        .new_cs       (new_cs),
        .new_ip       (new_ip),
        .load_new_ip  (load_new_ip),
        .insn_rd_en   (insn_rd_en),
        .insn_data    (insn_data),
        .insn_valid   (insn_valid),
        .data_start   (data_start),
        .data_write   (data_write),
        .data_word    (data_word),
        .data_seg     (data_seg),
        .data_offset  (data_offset),
        .data_wr_data (data_wr_data),
        .data_rd_data (data_rd_data),
        .data_done    (data_done),
        .mem_access   (mem_access),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_bytesel  (mem_bytesel),
        .mem_wr_data  (mem_wr_data),
        .mem_data     (mem_data),
        .mem_ack      (mem_ack)
    );

    biu_mem_model #(
        .SEED (seed ^ 32'h0000_ffff)
    ) u_mem (
        .clk     (clk),
        .reset   (reset),
        .access  (mem_access),
        .write   (mem_write),
        .address (mem_address),
        .bytesel (mem_bytesel),
        .wr_data (mem_wr_data),
        .rd_data (mem_data),
        .ack     (mem_ack)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // segment times 16 plus offset, wrapping at 1 MB
    function automatic logic [19:0] phys_addr(input seg_t seg, input offset_t off);
        return 20'(seg) * 20'd16 + 20'(off);
    endfunction

    // expected byte: last data write, else the memory fill pattern
    function automatic byte_t model_byte(input logic [19:0] a);
        logic [18:0] wa;
        logic [15:0] w;
        wa = a[19:1];
        w = wa[15:0] ^ {13'b0, wa[18:16]} ^ 16'h5a3c;
        if (written.exists(a)) begin
            return written[a];
        end
        return a[0] ? w[15:8] : w[7:0];
    endfunction

    task automatic report_failure(input string text);
        error_count++;
        $display("%s", text);
        $display("Some tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        assert (exp == act) else begin
            report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // IP load pulse, the FIFO is flushed in this cycle
    task automatic load_ip(input seg_t cs, input offset_t ip);
        new_cs      <= cs;
        new_ip      <= ip;
        load_new_ip <= 1'b1;
        insn_rd_en  <= 1'b0;
        @(posedge clk);
        load_new_ip <= 1'b0;
    endtask

    task automatic run_fetch(input logic [31:0] st_in, input bit own_region,
                             input int nbytes);
        logic [31:0] st;
        seg_t        cs;
        offset_t     ip;
        int          k;
        int          got;
        int          idle;
        int          stall;
        logic        rd;
        st = xorshift(st_in);
        cs = own_region ? 16'h2000 : {4'h0, st[11:0]};
        ip = own_region ? {8'h00, st[23:16]} : st[31:16];
        load_ip(cs, ip);
        k = 0;
        got = 0;
        idle = 0;
        stall = 0;
        while (got < nbytes) begin
            st = xorshift(st);
            // long stalls push the FIFO into back-pressure
            if (stall > 0) begin
                stall--;
            end else if (st[4:0] == 5'd0) begin
                stall = 8 + int'(st[8:6]);
            end
            rd = (stall == 0) && (st[10:9] != 2'b00);
            insn_rd_en <= rd;
            @(posedge clk);
            if (rd && insn_valid) begin
                check_value("fetch", {8'h00, model_byte(phys_addr(cs, ip + offset_t'(k)))},
                            {8'h00, insn_data});
                k++;
                got++;
                idle = 0;
            end else if (rd) begin
                idle++;
                if (idle > timeout_cycles) begin
                    report_failure("timed out waiting for an instruction byte");
                end
            end
            st = xorshift(st);
            // reload in mid-fetch
            if (st[5:0] == 6'd0) begin
                st = xorshift(st);
                cs = own_region ? 16'h2000 : {4'h0, st[11:0]};
                ip = own_region ? {8'h00, st[23:16]} : st[31:16];
                load_ip(cs, ip);
                k = 0;
                idle = 0;
            end
        end
        insn_rd_en <= 1'b0;
    endtask

    task automatic run_data(input logic [31:0] st_in, input bit writes_ok, input int nops);
        logic [31:0] st;
        logic        is_write;
        logic        is_word;
        seg_t        seg;
        offset_t     off;
        word_t       wdata;
        logic [19:0] a;
        word_t       exp;
        int          cnt;
        st = st_in;
        for (int i = 0; i < nops; i++) begin
            st = xorshift(st);
            repeat (int'(st[2:0])) @(posedge clk);
            st = xorshift(st);
            is_word  = st[0];
            is_write = writes_ok && st[1];
            wdata    = st[31:16];
            st = xorshift(st);
            // stores stay in their own region, away from the code
            if (is_write || st[0]) begin
                seg = 16'h2000;
                off = {8'h00, st[15:8]};
            end else begin
                seg = st[31:16];
                off = st[15:0];
            end
            data_start   <= 1'b1;
            data_write   <= is_write;
            data_word    <= is_word;
            data_seg     <= seg;
            data_offset  <= off;
            data_wr_data <= wdata;
            @(posedge clk);
            data_start <= 1'b0;
            cnt = 0;
            @(posedge clk);
            while (!data_done) begin
                cnt++;
                if (cnt > timeout_cycles) begin
                    report_failure("timed out waiting for data_done");
                end
                @(posedge clk);
            end
            a = phys_addr(seg, off);
            if (is_write) begin
                written[a] = wdata[7:0];
                if (is_word) begin
                    written[a + 20'd1] = wdata[15:8];
                end
            end else begin
                exp = is_word ? {model_byte(a + 20'd1), model_byte(a)}
                              : {8'h00, model_byte(a)};
                check_value(is_word ? "data word read" : "data byte read", exp, data_rd_data);
            end
        end
    endtask

    initial begin
        logic [31:0] st;
        bit          own;
        reset        = 1'b1;
        new_cs       = '0;
        new_ip       = '0;
        load_new_ip  = 1'b0;
        insn_rd_en   = 1'b0;
        data_start   = 1'b0;
        data_write   = 1'b0;
        data_word    = 1'b0;
        data_seg     = '0;
        data_offset  = '0;
        data_wr_data = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        // control outputs are quiet coming out of reset
        check_value("reset mem_access", 16'h0000, {15'h0000, mem_access});
        check_value("reset data_done", 16'h0000, {15'h0000, data_done});
        check_value("reset insn_valid", 16'h0000, {15'h0000, insn_valid});
        st = seed;
        for (int phase = 0; phase < num_phases; phase++) begin
            st = xorshift(st);
            // every fourth phase fetches from the stored region, reads only
            own = (phase % 4 == 3);
            fork
                run_fetch(st, own, 24 + int'(st[4:0]));
                run_data(xorshift(st ^ 32'h1234_5678), !own, own ? 4 : 6);
            join
        end
        if (error_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "errors were found");
        end
    end

endmodule

`default_nettype wire

//--- biu_top.f
common/biu_types_pkg.sv
common/biu_bus_pkg.sv
common/mem_req_if.sv
prefetch/prefetch.sv
prefetch/insn_fifo.sv
rtl/data_access.sv
rtl/bus_arbiter.sv
rtl/biu_top.sv
testbench/biu_mem_model.sv
testbench/biu_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = biu_tb
FILELIST  = biu_top.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
